/* logic/line_gfx_pkg.sv */
/*
 * shared types for the line drawing display: coordinates, colours,
 * line jobs, pixel writes, video bus, 16-entry palette and FSM states
 */
`default_nettype none

package line_gfx_pkg;

    localparam int CORDW = 16;  // coordinate width

    typedef logic signed [CORDW-1:0] coord_t;
    typedef logic [3:0] cidx_t;  // palette index

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
        cidx_t  cidx;
    } line_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        cidx_t  cidx;
    } pix_write_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
        rgb_t rgb;
    } video_t;

    localparam rgb_t PALETTE [16] = '{
        rgb_t'(12'h000),  // black
        rgb_t'(12'h123),  // dark blue
        rgb_t'(12'h727),  // purple
        rgb_t'(12'h085),  // dark green
        rgb_t'(12'hA53),  // brown
        rgb_t'(12'h555),  // dark grey
        rgb_t'(12'hCCC),  // light grey
        rgb_t'(12'hFFE),  // off white
        rgb_t'(12'hF00),  // red
        rgb_t'(12'hFA0),  // orange
        rgb_t'(12'hFF0),  // yellow
        rgb_t'(12'h0F0),  // green
        rgb_t'(12'h00F),  // blue
        rgb_t'(12'h879),  // lavender
        rgb_t'(12'hF7A),  // pink
        rgb_t'(12'hFFF)   // white
    };

    typedef enum logic [1:0] {SEQ_IDLE, SEQ_INIT, SEQ_DRAW, SEQ_DONE} seq_state_t;
    typedef enum logic [1:0] {DRAW_IDLE, DRAW_INIT, DRAW_RUN} draw_state_t;

endpackage

`default_nettype wire

/* logic/display_timing.sv */
/*
 * display timing generator: screen counters, active-high syncs,
 * data enable and frame/line strobes
 */
`default_nettype none

module display_timing import line_gfx_pkg::*; #(
    parameter int H_ACTIVE = 64,
    parameter int H_FRONT  = 4,
    parameter int H_SYNC   = 8,
    parameter int H_BACK   = 4,
    parameter int V_ACTIVE = 48,
    parameter int V_FRONT  = 2,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 2
) (
    input  wire logic clk_pix,
    input  wire logic reset,
    output coord_t    sx,
    output coord_t    sy,
    output logic      hsync,
    output logic      vsync,
    output logic      de,
    output logic      frame,
    output logic      line
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // active region starts at zero, blanking follows
    localparam coord_t HA_END = coord_t'(H_ACTIVE);
    localparam coord_t HS_STA = coord_t'(H_ACTIVE + H_FRONT);
    localparam coord_t HS_END = coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam coord_t H_LAST = coord_t'(H_TOTAL - 1);
    localparam coord_t H_END  = coord_t'(H_TOTAL);
    localparam coord_t VA_END = coord_t'(V_ACTIVE);
    localparam coord_t VS_STA = coord_t'(V_ACTIVE + V_FRONT);
    localparam coord_t VS_END = coord_t'(V_ACTIVE + V_FRONT + V_SYNC);
    localparam coord_t V_LAST = coord_t'(V_TOTAL - 1);

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_LAST) begin
            sx <= '0;
            sy <= (sy == V_LAST) ? coord_t'(0) : sy + coord_t'(1);  // wrap at frame end
        end else begin
            sx <= sx + coord_t'(1);
        end
    end

    always_comb begin
        hsync = (sx >= HS_STA) && (sx < HS_END);
        vsync = (sy >= VS_STA) && (sy < VS_END);
        de    = (sx < HA_END) && (sy < VA_END);
        frame = (sx == '0) && (sy == VA_END);  // first blank line
        line  = (sx == '0);
    end

    a_sx_range: assert property (@(posedge clk_pix) disable iff (reset) sx < H_END)
        else $error("sx out of range: %0d", sx);

endmodule

`default_nettype wire

/* logic/line_drawer.sv */
/*
 * Bresenham line engine for all octants
 * walks x0,y0 to x1,y1 inclusive, one pixel per cycle with oe high
 */
`default_nettype none

module line_drawer import line_gfx_pkg::*; (
    input  wire logic  clk_pix,
    input  wire logic  reset,
    input  wire logic  start,
    input  wire logic  oe,
    input  wire line_t job,
    output pix_write_t wr,
    output logic       wr_en,
    output logic       drawing,
    output logic       done
);

    typedef logic signed [CORDW+1:0] err_t;  // headroom for doubled error

    draw_state_t state;
    coord_t x, y;
    coord_t dx, dy;            // dx positive, dy negative
    coord_t dx_init, dy_init;
    logic   step_right, step_down;
    err_t   err, err_step;
    logic   movx, movy, at_end;

    always_comb begin
        dx_init  = (job.x1 >= job.x0) ? job.x1 - job.x0 : job.x0 - job.x1;
        dy_init  = (job.y1 >= job.y0) ? job.y0 - job.y1 : job.y1 - job.y0;
        movx     = (err <<< 1) >= err_t'(dy);
        movy     = (err <<< 1) <= err_t'(dx);
        err_step = err + (movx ? err_t'(dy) : '0) + (movy ? err_t'(dx) : '0);
        at_end   = (x == job.x1) && (y == job.y1);
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state <= DRAW_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                DRAW_IDLE: if (start) state <= DRAW_INIT;
                DRAW_INIT: state <= DRAW_RUN;
                DRAW_RUN: begin
                    if (oe && at_end) begin  // last pixel goes out this cycle
                        state <= DRAW_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= DRAW_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_pix) begin
        if (state == DRAW_INIT) begin
            x          <= job.x0;
            y          <= job.y0;
            dx         <= dx_init;
            dy         <= dy_init;
            step_right <= (job.x1 >= job.x0);
            step_down  <= (job.y1 >= job.y0);
            err        <= err_t'(dx_init) + err_t'(dy_init);
        end else if (state == DRAW_RUN && oe && !at_end) begin
            if (movx) x <= step_right ? x + coord_t'(1) : x - coord_t'(1);
            if (movy) y <= step_down ? y + coord_t'(1) : y - coord_t'(1);
            err <= err_step;
        end
    end

    always_comb begin
        drawing = (state == DRAW_RUN);
        wr_en   = drawing && oe;  // stall while display reads
        wr      = '{x: x, y: y, cidx: job.cidx};
    end

    a_no_restart: assert property (@(posedge clk_pix) disable iff (reset) start |-> !drawing)
        else $error("line start while drawing");

endmodule

`default_nettype wire

/* logic/framebuffer.sv */
/*
 * colour index framebuffer with clipped write port,
 * raster read through the palette and display busy flag
 */
`default_nettype none

module framebuffer import line_gfx_pkg::*; #(
    parameter int FB_WIDTH  = 64,
    parameter int FB_HEIGHT = 48
) (
    input  wire logic       clk_pix,
    input  wire logic       reset,
    input  wire pix_write_t wr,
    input  wire logic       wr_en,
    input  wire coord_t     sx,
    input  wire coord_t     sy,
    input  wire logic       de,
    output logic            busy,
    output rgb_t            rgb
);

    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int ADDRW     = $clog2(FB_PIXELS);
    localparam coord_t X_END = coord_t'(FB_WIDTH);
    localparam coord_t Y_END = coord_t'(FB_HEIGHT);

    cidx_t mem [FB_PIXELS] = '{default: '0};  // starts all black

    logic [ADDRW-1:0] wr_addr, rd_addr;
    logic wr_inside, wr_accept;
    logic rd_inside;

    always_comb busy = de;  // display owns the memory during active video

    // write side, coordinates outside the buffer are dropped
    always_comb begin
        wr_inside = (wr.x >= coord_t'(0)) && (wr.x < X_END) &&
                    (wr.y >= coord_t'(0)) && (wr.y < Y_END);
        wr_addr   = ADDRW'(int'(wr.y) * FB_WIDTH + int'(wr.x));
        wr_accept = wr_en && !busy && wr_inside;
    end

    always_ff @(posedge clk_pix) begin
        if (wr_accept) mem[wr_addr] <= wr.cidx;
    end

    // read side follows the raster
    always_comb begin
        rd_inside = de && (sx >= coord_t'(0)) && (sx < X_END) &&
                    (sy >= coord_t'(0)) && (sy < Y_END);
        rd_addr   = ADDRW'(int'(sy) * FB_WIDTH + int'(sx));
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            rgb <= PALETTE[0];
        end else begin
            rgb <= rd_inside ? PALETTE[mem[rd_addr]] : PALETTE[0];  // black in blanking
        end
    end

    // the drawer must honour oe, so a request never meets the display
    a_no_write_busy: assert property (@(posedge clk_pix) disable iff (reset) wr_en |-> !de)
        else $error("write request during active video at %0d,%0d", wr.x, wr.y);

endmodule

`default_nettype wire

/* logic/outline_sequencer.sv */
/*
 * outline sequencer FSM: four framebuffer edges then one diagonal,
 * one line job at a time, holds draw_complete when finished
 */
`default_nettype none

module outline_sequencer import line_gfx_pkg::*; #(
    parameter int FB_WIDTH  = 64,
    parameter int FB_HEIGHT = 48
) (
    input  wire logic clk_pix,
    input  wire logic reset,
    input  wire logic frame,
    input  wire logic done,
    output line_t     job,
    output logic      start,
    output logic      draw_complete
);

    localparam logic [2:0] LAST_ID = 3'd4;
    localparam coord_t X_MAX = coord_t'(FB_WIDTH - 1);
    localparam coord_t Y_MAX = coord_t'(FB_HEIGHT - 1);
    localparam coord_t ORIGIN = '0;

    seq_state_t state;
    logic [2:0] line_id;

    function automatic line_t line_job(input logic [2:0] id);
        line_t j;
        case (id)
            3'd0: j = '{x0: ORIGIN, y0: ORIGIN, x1: X_MAX, y1: ORIGIN, cidx: 4'h8};  // top, red
            3'd1: j = '{x0: X_MAX, y0: ORIGIN, x1: X_MAX, y1: Y_MAX, cidx: 4'hA};  // right
            3'd2: j = '{x0: X_MAX, y0: Y_MAX, x1: ORIGIN, y1: Y_MAX, cidx: 4'hB};  // bottom
            3'd3: j = '{x0: ORIGIN, y0: Y_MAX, x1: ORIGIN, y1: ORIGIN, cidx: 4'hC};  // left
            3'd4: j = '{x0: ORIGIN, y0: ORIGIN, x1: Y_MAX, y1: Y_MAX, cidx: 4'hF};  // 45 deg
            default: j = '0;
        endcase
        return j;
    endfunction

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state   <= SEQ_IDLE;
            line_id <= '0;
            start   <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                SEQ_IDLE: if (frame) state <= SEQ_INIT;  // wait for first blanking
                SEQ_INIT: begin
                    start <= 1'b1;
                    state <= SEQ_DRAW;
                end
                SEQ_DRAW: begin
                    if (done) begin
                        if (line_id == LAST_ID) begin
                            state <= SEQ_DONE;
                        end else begin
                            line_id <= line_id + 3'd1;
                            state   <= SEQ_INIT;
                        end
                    end
                end
                SEQ_DONE: state <= SEQ_DONE;
                default:  state <= SEQ_IDLE;
            endcase
        end
    end

    // job is loaded on entry to SEQ_INIT, a cycle ahead of start
    always_ff @(posedge clk_pix) begin
        if (state == SEQ_IDLE && frame) begin
            job <= line_job(3'd0);
        end else if (state == SEQ_DRAW && done && line_id != LAST_ID) begin
            job <= line_job(line_id + 3'd1);
        end
    end

    always_comb draw_complete = (state == SEQ_DONE);

    a_line_id_range: assert property (@(posedge clk_pix) disable iff (reset) line_id <= LAST_ID)
        else $error("line counter overrun: %0d", line_id);

endmodule

`default_nettype wire

/* logic/line_render_top.sv */
/*
 * line render top level: timing, outline sequencer, line drawer,
 * framebuffer and the video output alignment registers
 */
`default_nettype none

module line_render_top import line_gfx_pkg::*; #(
    parameter int H_ACTIVE = 64,
    parameter int H_FRONT  = 4,
    parameter int H_SYNC   = 8,
    parameter int H_BACK   = 4,
    parameter int V_ACTIVE = 48,
    parameter int V_FRONT  = 2,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 2
) (
    input  wire logic clk_pix,
    input  wire logic reset,
    output video_t    video,
    output logic      draw_complete
);

    localparam int FB_WIDTH  = H_ACTIVE;  // framebuffer matches the raster
    localparam int FB_HEIGHT = V_ACTIVE;

    coord_t sx, sy;
    logic hsync, vsync, de, frame;

    display_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) timing_inst (
        .clk_pix, .reset, .sx, .sy, .hsync, .vsync, .de, .frame, .line()
    );

    line_t job;
    logic draw_start, draw_done, drawing;

    outline_sequencer #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) seq_inst (
        .clk_pix, .reset, .frame, .done(draw_done), .job, .start(draw_start),
        .draw_complete
    );

    pix_write_t wr;
    logic wr_en, fb_busy;
    rgb_t fb_rgb;

    line_drawer drawer_inst (
        .clk_pix, .reset, .start(draw_start), .oe(!fb_busy), .job,
        .wr, .wr_en, .drawing, .done(draw_done)
    );

    framebuffer #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) fb_inst (
        .clk_pix, .reset, .wr, .wr_en, .sx, .sy, .de, .busy(fb_busy), .rgb(fb_rgb)
    );

    // sync and de pass two stages, rgb already has one from the read
    logic hsync_p1, vsync_p1, de_p1;
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            hsync_p1 <= 1'b0;
            vsync_p1 <= 1'b0;
            de_p1    <= 1'b0;
            video    <= '0;
        end else begin
            hsync_p1 <= hsync;
            vsync_p1 <= vsync;
            de_p1    <= de;
            video    <= '{hsync: hsync_p1, vsync: vsync_p1, de: de_p1, rgb: fb_rgb};
        end
    end

    a_idle_when_complete: assert property (@(posedge clk_pix) disable iff (reset)
        draw_complete |-> !drawing && !wr_en)
        else $error("drawer active after completion");

endmodule

`default_nettype wire

/* testbench/tb_line_render.sv */
/*
 * testbench for the line render top level: clock, reset, watchdog,
 * reference pixel model, compare tasks and directed video tests
 */
`default_nettype none

module tb_line_render import line_gfx_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int H_ACTIVE = 64;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 8;
    localparam int H_BACK   = 4;
    localparam int V_ACTIVE = 48;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 2;

    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FB_WIDTH     = H_ACTIVE;
    localparam int FB_HEIGHT    = V_ACTIVE;
    localparam int FB_PIXELS    = FB_WIDTH * FB_HEIGHT;
    localparam int PIX_AW       = $clog2(FB_PIXELS);
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 2;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int WATCHDOG_NS  = 6 * FRAME_CYCLES * CLK_PERIOD;  // six frames

    // palette indices of the outline colours
    localparam cidx_t BLACK  = 4'd0;
    localparam cidx_t RED    = 4'd8;
    localparam cidx_t YELLOW = 4'd10;
    localparam cidx_t GREEN  = 4'd11;
    localparam cidx_t BLUE   = 4'd12;
    localparam cidx_t WHITE  = 4'd15;

    logic   clk_pix;
    logic   reset;
    video_t video;
    logic   draw_complete;

    cidx_t model [FB_PIXELS];  // expected colour index per pixel

    line_render_top #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) uut (
        .clk_pix, .reset, .video, .draw_complete
    );

    always #(CLK_PERIOD / 2) clk_pix = ~clk_pix;

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_video_idle(input string name, input video_t got);
        if (got !== video_t'(0)) begin
            $display("FAILED %s: got %h, expected %h", name, got, video_t'(0));
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [PIX_AW-1:0] pix_index(input int x, input int y);
        return PIX_AW'(y * FB_WIDTH + x);
    endfunction

    // outline in drawing order, later lines win at shared pixels
    task automatic build_model();
        model = '{default: BLACK};
        for (int x = 0; x < FB_WIDTH; x++) model[pix_index(x, 0)] = RED;
        for (int y = 0; y < FB_HEIGHT; y++) model[pix_index(FB_WIDTH - 1, y)] = YELLOW;
        for (int x = 0; x < FB_WIDTH; x++) model[pix_index(x, FB_HEIGHT - 1)] = GREEN;
        for (int y = 0; y < FB_HEIGHT; y++) model[pix_index(0, y)] = BLUE;
        for (int i = 0; i < FB_HEIGHT; i++) model[pix_index(i, i)] = WHITE;  // x equals y
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_pix);
        #1 reset = 1'b0;
    endtask

    // vsync lies between the last active row and the next frame
    task automatic wait_vsync_high();
        while (!video.vsync) @(negedge clk_pix);
    endtask

    // output pipeline still carries reset values for two cycles
    task automatic test_reset_state();
        repeat (2) begin
            @(negedge clk_pix);
            check_video_idle("video after reset", video);
            check_bit("draw_complete after reset", draw_complete, 1'b0);
        end
        $display("reset state checked");
    endtask

    task automatic test_blank_first_frame();
        int   de_cycles;
        logic vsync_q;
        logic frame_end;
        de_cycles = 0;
        vsync_q   = 1'b0;
        frame_end = 1'b0;
        while (!frame_end) begin
            @(negedge clk_pix);
            if (video.de) begin
                check_rgb($sformatf("video.rgb blank pixel %0d", de_cycles),
                          video.rgb, PALETTE[BLACK]);
                de_cycles++;
            end
            frame_end = video.vsync && !vsync_q;
            vsync_q   = video.vsync;
        end
        check_count("de cycles in first frame", de_cycles, FB_PIXELS);
        $display("blank first frame checked");
    endtask

    // one frame from vsync rise to vsync rise
    task automatic test_sync_structure();
        int   cycles, frame_de, line_de, hs_high, vs_high, since_hs, active_lines;
        logic seen_hs, hsync_q, vsync_q, frame_end;
        cycles       = 0;
        frame_de     = 0;
        line_de      = 0;
        hs_high      = 0;
        vs_high      = 1;  // the rising cycle itself
        since_hs     = 0;
        active_lines = 0;
        seen_hs      = 1'b0;
        hsync_q      = video.hsync;
        vsync_q      = video.vsync;
        frame_end    = 1'b0;
        while (!frame_end) begin
            @(negedge clk_pix);
            cycles++;
            frame_end = video.vsync && !vsync_q;
            if (video.hsync && !hsync_q) begin
                if (seen_hs) begin
                    check_count("hsync period", since_hs, H_TOTAL);
                    check_count("hsync width", hs_high, H_SYNC);
                    if (line_de != 0) begin
                        check_count("de cycles per line", line_de, H_ACTIVE);
                        active_lines++;
                    end
                end
                seen_hs  = 1'b1;
                since_hs = 0;
                hs_high  = 0;
                line_de  = 0;
            end
            since_hs++;
            if (video.hsync) hs_high++;
            if (video.vsync && !frame_end) vs_high++;  // stop at the next frame
            if (video.de) begin
                line_de++;
                frame_de++;
            end
            hsync_q = video.hsync;
            vsync_q = video.vsync;
        end
        check_count("clk_pix cycles per frame", cycles, FRAME_CYCLES);
        check_count("vsync width", vs_high, V_SYNC * H_TOTAL);
        check_count("de cycles per frame", frame_de, FB_PIXELS);
        check_count("active lines per frame", active_lines, V_ACTIVE);
        $display("sync structure checked");
    endtask

    task automatic test_completion();
        while (!draw_complete) @(negedge clk_pix);  // watchdog bounds this
        $display("draw_complete seen at %0t", $time);
    endtask

    // pixel position comes from counting de, not from the DUT
    task automatic test_picture(input string label);
        int n;
        int x;
        int y;
        n = 0;
        wait_vsync_high();
        while (n < FB_PIXELS) begin
            @(negedge clk_pix);
            check_bit("draw_complete", draw_complete, 1'b1);
            if (video.de) begin
                x = n % FB_WIDTH;
                y = n / FB_WIDTH;
                check_rgb($sformatf("video.rgb %s at (%0d,%0d)", label, x, y),
                          video.rgb, PALETTE[model[pix_index(x, y)]]);
                n++;
            end
        end
        $display("picture checked on %s", label);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        abort_run();
    end

    initial begin
        clk_pix = 1'b0;
        reset   = 1'b1;
        build_model();
        apply_reset();
        test_reset_state();
        test_blank_first_frame();
        test_sync_structure();
        test_completion();
        test_picture("first frame");
        test_picture("second frame");  // memory must be unchanged
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
logic/line_gfx_pkg.sv
logic/display_timing.sv
logic/line_drawer.sv
logic/framebuffer.sv
logic/outline_sequencer.sv
logic/line_render_top.sv
testbench/tb_line_render.sv

/* Makefile */
# Verilator build for the line render project

VERILATOR  ?= verilator
BUILD_DIR  ?= obj_dir
TB_TOP     ?= tb_line_render
RTL_TOP    ?= line_render_top
FILE_LIST  ?= vlog.f
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0

RTL_SRCS := logic/line_gfx_pkg.sv \
            logic/display_timing.sv \
            logic/line_drawer.sv \
            logic/framebuffer.sv \
            logic/outline_sequencer.sv \
            logic/line_render_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) \
		-o V$(TB_TOP) -f $(FILE_LIST)
	-$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -q "Test OK" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
